//--- source/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int WORD_SIZE = 16;
    localparam int REG_COUNT = 4;
    localparam int REG_BITS = 2;

    localparam logic [3:0] OP_BNE = 4'd0;
    localparam logic [3:0] OP_BEQ = 4'd1;
    localparam logic [3:0] OP_ADI = 4'd4;
    localparam logic [3:0] OP_LHI = 4'd6;
    localparam logic [3:0] OP_LWD = 4'd7;
    localparam logic [3:0] OP_SWD = 4'd8;
    localparam logic [3:0] OP_JMP = 4'd9;
    localparam logic [3:0] OP_RTYPE = 4'd15;

    // func field, only meaningful under OP_RTYPE
    localparam logic [5:0] FUNC_ADD = 6'd0;
    localparam logic [5:0] FUNC_SUB = 6'd1;
    localparam logic [5:0] FUNC_AND = 6'd2;
    localparam logic [5:0] FUNC_ORR = 6'd3;
    localparam logic [5:0] FUNC_JPR = 6'd25;
    localparam logic [5:0] FUNC_WWD = 6'd28;
    localparam logic [5:0] FUNC_HLT = 6'd29;

    typedef struct packed {
        logic [3:0] opcode;
        logic [REG_BITS-1:0] rs;
        logic [REG_BITS-1:0] rt;
        logic [REG_BITS-1:0] rd;
        logic [5:0] func;
    } regForm_t;

    typedef struct packed {
        logic [3:0] opcode;
        logic [REG_BITS-1:0] rs;
        logic [REG_BITS-1:0] rt;
        logic [7:0] imm8;
    } immForm_t;

    typedef struct packed {
        logic [3:0] opcode;
        logic [11:0] target12;
    } jumpForm_t;

    // one fetched word, read through whichever form its opcode selects
    typedef union packed {
        regForm_t rType;
        immForm_t iType;
        jumpForm_t jType;
    } instr_u;

endpackage

`default_nettype wire

//--- source/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    // control vector bit positions
    localparam int CTRL_WIDTH = 11;
    localparam int C_REG_WRITE = 0;
    localparam int C_MEM_TO_REG = 1;
    localparam int C_MEM_READ = 2;
    localparam int C_MEM_WRITE = 3;
    localparam int C_IS_BRANCH = 4;
    localparam int C_BRANCH_EQ = 5;
    localparam int C_ALU_SRC = 6;
    localparam int C_IS_JUMPR = 7;
    localparam int C_WWD = 8;
    localparam int C_HLT = 9;
    localparam int C_LHI = 10;

    localparam int ALU_OP_BITS = 2;
    localparam logic [ALU_OP_BITS-1:0] ALU_ADD = 2'd0;
    localparam logic [ALU_OP_BITS-1:0] ALU_SUB = 2'd1;
    localparam logic [ALU_OP_BITS-1:0] ALU_AND = 2'd2;
    localparam logic [ALU_OP_BITS-1:0] ALU_ORR = 2'd3;

    // operand source in execute
    localparam int FWD_BITS = 2;
    localparam logic [FWD_BITS-1:0] FWD_NONE = 2'd0;
    localparam logic [FWD_BITS-1:0] FWD_MEM = 2'd1;
    localparam logic [FWD_BITS-1:0] FWD_WB = 2'd2;

endpackage

`default_nettype wire

//--- source/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  logic Clk,
    input  logic rstN,
    input  logic [isaPkg::REG_BITS-1:0] rs,
    input  logic [isaPkg::REG_BITS-1:0] rt,
    output logic [isaPkg::WORD_SIZE-1:0] readData1,
    output logic [isaPkg::WORD_SIZE-1:0] readData2,
    input  logic [isaPkg::REG_BITS-1:0] writeIdx,
    input  logic [isaPkg::WORD_SIZE-1:0] writeData,
    input  logic writeEn
);

    logic [isaPkg::WORD_SIZE-1:0] regs [isaPkg::REG_COUNT];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (writeEn) begin
            regs[writeIdx] <= writeData;
        end
    end

    // writeback lands in decode during the same cycle
    assign readData1 = (writeEn && writeIdx == rs) ? writeData : regs[rs];
    assign readData2 = (writeEn && writeIdx == rt) ? writeData : regs[rt];

    // once reset has been held for a cycle the pipeline is empty, so writeback stays idle
    noWriteInReset: assert property (@(posedge Clk) (!rstN && $past(!rstN)) |-> !writeEn)
        else $error("register write while reset is held");

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  logic [isaPkg::WORD_SIZE-1:0] a,
    input  logic [isaPkg::WORD_SIZE-1:0] b,
    input  logic [ctrlPkg::ALU_OP_BITS-1:0] aluOp,
    output logic [isaPkg::WORD_SIZE-1:0] result,
    output logic equal
);

    always_comb begin
        case (aluOp)
            ctrlPkg::ALU_ADD: begin
                result = a + b;
            end
            ctrlPkg::ALU_SUB: begin
                result = a - b;
            end
            ctrlPkg::ALU_AND: begin
                result = a & b;
            end
            ctrlPkg::ALU_ORR: begin
                result = a | b;
            end
            default: begin
                result = a + b;
            end
        endcase
    end

    // branch compare runs on the forwarded operands, independent of aluOp
    assign equal = (a == b);

endmodule

`default_nettype wire

//--- source/pipelineControl.sv
`timescale 1ns/100ps
`default_nettype none

module pipelineControl (
    input  isaPkg::instr_u instrId,
    input  logic validId,
    input  logic [isaPkg::REG_BITS-1:0] exRs,
    input  logic [isaPkg::REG_BITS-1:0] exRt,
    input  logic [isaPkg::REG_BITS-1:0] exRd,
    input  logic exMemRead,
    input  logic exValid,
    input  logic [isaPkg::REG_BITS-1:0] memRd,
    input  logic memRegWrite,
    input  logic [isaPkg::REG_BITS-1:0] wbRd,
    input  logic wbRegWrite,
    input  logic redirectEx,
    output logic [ctrlPkg::CTRL_WIDTH-1:0] ctrlId,
    output logic [isaPkg::REG_BITS-1:0] destId,
    output logic [ctrlPkg::ALU_OP_BITS-1:0] aluOpId,
    output logic [ctrlPkg::FWD_BITS-1:0] forwardA,
    output logic [ctrlPkg::FWD_BITS-1:0] forwardB,
    output logic stallId,
    output logic flushIf,
    output logic flushId,
    output logic jumpId
);

    logic useRs;
    logic useRt;

    function automatic logic [ctrlPkg::FWD_BITS-1:0] pickForward(
        input logic [isaPkg::REG_BITS-1:0] src,
        input logic [isaPkg::REG_BITS-1:0] memDst,
        input logic memWrites,
        input logic [isaPkg::REG_BITS-1:0] wbDst,
        input logic wbWrites
    );
        // younger result wins
        if (memWrites && memDst == src) begin
            return ctrlPkg::FWD_MEM;
        end
        if (wbWrites && wbDst == src) begin
            return ctrlPkg::FWD_WB;
        end
        return ctrlPkg::FWD_NONE;
    endfunction

    always_comb begin
        ctrlId = '0;
        aluOpId = ctrlPkg::ALU_ADD;
        destId = instrId.iType.rt;
        useRs = 1'b1;
        useRt = 1'b0;
        case (instrId.rType.opcode)
            isaPkg::OP_RTYPE: begin
                destId = instrId.rType.rd;
                useRt = 1'b1;
                ctrlId[ctrlPkg::C_REG_WRITE] = 1'b1;
                case (instrId.rType.func)
                    isaPkg::FUNC_ADD: aluOpId = ctrlPkg::ALU_ADD;
                    isaPkg::FUNC_SUB: aluOpId = ctrlPkg::ALU_SUB;
                    isaPkg::FUNC_AND: aluOpId = ctrlPkg::ALU_AND;
                    isaPkg::FUNC_ORR: aluOpId = ctrlPkg::ALU_ORR;
                    default: begin
                        // jpr, wwd, hlt: no register result, rt unused
                        useRt = 1'b0;
                        ctrlId[ctrlPkg::C_REG_WRITE] = 1'b0;
                        ctrlId[ctrlPkg::C_IS_JUMPR] = (instrId.rType.func == isaPkg::FUNC_JPR);
                        ctrlId[ctrlPkg::C_WWD] = (instrId.rType.func == isaPkg::FUNC_WWD);
                        ctrlId[ctrlPkg::C_HLT] = (instrId.rType.func == isaPkg::FUNC_HLT);
                        useRs = (instrId.rType.func != isaPkg::FUNC_HLT);
                    end
                endcase
            end
            isaPkg::OP_ADI: begin
                ctrlId[ctrlPkg::C_REG_WRITE] = 1'b1;
                ctrlId[ctrlPkg::C_ALU_SRC] = 1'b1;
            end
            isaPkg::OP_LHI: begin
                ctrlId[ctrlPkg::C_REG_WRITE] = 1'b1;
                ctrlId[ctrlPkg::C_LHI] = 1'b1;
                useRs = 1'b0;
            end
            isaPkg::OP_LWD: begin
                ctrlId[ctrlPkg::C_REG_WRITE] = 1'b1;
                ctrlId[ctrlPkg::C_MEM_TO_REG] = 1'b1;
                ctrlId[ctrlPkg::C_MEM_READ] = 1'b1;
                ctrlId[ctrlPkg::C_ALU_SRC] = 1'b1;
            end
            isaPkg::OP_SWD: begin
                ctrlId[ctrlPkg::C_MEM_WRITE] = 1'b1;
                ctrlId[ctrlPkg::C_ALU_SRC] = 1'b1;
                useRt = 1'b1;
            end
            isaPkg::OP_BNE, isaPkg::OP_BEQ: begin
                ctrlId[ctrlPkg::C_IS_BRANCH] = 1'b1;
                ctrlId[ctrlPkg::C_BRANCH_EQ] = (instrId.iType.opcode == isaPkg::OP_BEQ);
                useRt = 1'b1;
            end
            default: begin
                // jmp and unknown opcodes read nothing
                useRs = 1'b0;
            end
        endcase
    end

    // load in execute feeding a source still in decode
    assign stallId = validId && exValid && exMemRead
        && ((useRs && exRd == instrId.rType.rs) || (useRt && exRd == instrId.rType.rt));

    assign forwardA = pickForward(exRs, memRd, memRegWrite, wbRd, wbRegWrite);
    assign forwardB = pickForward(exRt, memRd, memRegWrite, wbRd, wbRegWrite);

    assign jumpId = validId && (instrId.jType.opcode == isaPkg::OP_JMP);
    assign flushId = redirectEx;
    assign flushIf = redirectEx || jumpId;

endmodule

`default_nettype wire

//--- source/pipeDatapath.sv
`timescale 1ns/100ps
`default_nettype none

module pipeDatapath (
    input  logic Clk,
    input  logic rstN,
    output logic [isaPkg::WORD_SIZE-1:0] instAddr,
    input  logic [isaPkg::WORD_SIZE-1:0] instData,
    output logic [isaPkg::WORD_SIZE-1:0] dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output logic [isaPkg::WORD_SIZE-1:0] dataWData,
    input  logic [isaPkg::WORD_SIZE-1:0] dataRData,
    output logic halted,
    output logic [isaPkg::WORD_SIZE-1:0] outputPort,
    output logic outputStrobe,
    output logic [isaPkg::WORD_SIZE-1:0] numInst,
    output isaPkg::instr_u instrId,
    output logic validId,
    input  logic [ctrlPkg::CTRL_WIDTH-1:0] ctrlId,
    input  logic [isaPkg::REG_BITS-1:0] destId,
    input  logic [ctrlPkg::ALU_OP_BITS-1:0] aluOpId,
    input  logic [ctrlPkg::FWD_BITS-1:0] forwardA,
    input  logic [ctrlPkg::FWD_BITS-1:0] forwardB,
    input  logic stallId, flushIf, flushId, jumpId,
    output logic redirectEx,
    output logic [isaPkg::REG_BITS-1:0] exRs, exRt, exRd,
    output logic exMemRead,
    output logic exValid,
    output logic [isaPkg::REG_BITS-1:0] memRd,
    output logic memRegWrite,
    output logic [isaPkg::REG_BITS-1:0] wbRd,
    output logic wbRegWrite,
    input  logic [isaPkg::WORD_SIZE-1:0] readData1, readData2,
    output logic [isaPkg::REG_BITS-1:0] regWriteIdx,
    output logic [isaPkg::WORD_SIZE-1:0] regWriteData,
    output logic regWriteEn,
    output logic [isaPkg::WORD_SIZE-1:0] aluA, aluB,
    output logic [ctrlPkg::ALU_OP_BITS-1:0] aluOp,
    input  logic [isaPkg::WORD_SIZE-1:0] aluResult,
    input  logic aluEqual
);

    logic [isaPkg::WORD_SIZE-1:0] pc, pcPlusOne, nextPc, redirectTarget, ifIdPc;
    logic [isaPkg::WORD_SIZE-1:0] idExData1, idExData2, idExImm, idExPc;
    logic [isaPkg::WORD_SIZE-1:0] fwdB, exResult, exMemResult, exMemStore, memWbData;
    logic [ctrlPkg::CTRL_WIDTH-1:0] idExCtrl, exMemCtrl, memWbCtrl;
    logic exMemValid, memWbValid, haltPending, killId;

    function automatic logic [isaPkg::WORD_SIZE-1:0] pickOperand(
        input logic [ctrlPkg::FWD_BITS-1:0] sel,
        input logic [isaPkg::WORD_SIZE-1:0] regVal,
        input logic [isaPkg::WORD_SIZE-1:0] memVal,
        input logic [isaPkg::WORD_SIZE-1:0] wbVal
    );
        if (sel == ctrlPkg::FWD_MEM) begin
            return memVal;
        end
        if (sel == ctrlPkg::FWD_WB) begin
            return wbVal;
        end
        return regVal;
    endfunction

    // hlt past decode is certain, so everything younger is dropped and fetch freezes
    assign haltPending = idExCtrl[ctrlPkg::C_HLT] || exMemCtrl[ctrlPkg::C_HLT]
        || memWbCtrl[ctrlPkg::C_HLT] || halted;
    assign killId = stallId || flushId || haltPending || !validId;

    assign instAddr = pc;
    assign pcPlusOne = pc + 1'b1;
    always_comb begin
        if (stallId || haltPending) begin
            nextPc = pc;
        end else if (redirectEx) begin
            nextPc = redirectTarget;
        end else if (jumpId) begin
            nextPc = {ifIdPc[isaPkg::WORD_SIZE-1:12], instrId.jType.target12};
        end else begin
            nextPc = pcPlusOne;
        end
    end

    // execute
    assign aluA = pickOperand(forwardA, idExData1, exMemResult, memWbData);
    assign fwdB = pickOperand(forwardB, idExData2, exMemResult, memWbData);
    assign aluB = idExCtrl[ctrlPkg::C_ALU_SRC] ? idExImm
        : (idExCtrl[ctrlPkg::C_WWD] ? '0 : fwdB);
    assign exResult = idExCtrl[ctrlPkg::C_LHI] ? {idExImm[7:0], 8'h00} : aluResult;
    assign redirectEx = exValid && (idExCtrl[ctrlPkg::C_IS_JUMPR]
        || (idExCtrl[ctrlPkg::C_IS_BRANCH] && aluEqual == idExCtrl[ctrlPkg::C_BRANCH_EQ]));
    assign redirectTarget = idExCtrl[ctrlPkg::C_IS_JUMPR] ? aluA : idExPc + idExImm;
    assign exMemRead = idExCtrl[ctrlPkg::C_MEM_READ];

    // memory and writeback
    assign dataAddr = exMemResult;
    assign dataRead = exMemCtrl[ctrlPkg::C_MEM_READ];
    assign dataWrite = exMemCtrl[ctrlPkg::C_MEM_WRITE];
    assign dataWData = exMemStore;
    assign memRegWrite = exMemCtrl[ctrlPkg::C_REG_WRITE];
    assign regWriteData = memWbData;
    assign regWriteEn = memWbCtrl[ctrlPkg::C_REG_WRITE];
    assign wbRd = regWriteIdx;
    assign wbRegWrite = regWriteEn;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc <= '0;
            validId <= 1'b0;
            exValid <= 1'b0;
            idExCtrl <= '0;
            exMemValid <= 1'b0;
            exMemCtrl <= '0;
            memWbValid <= 1'b0;
            memWbCtrl <= '0;
        end else begin
            pc <= nextPc;
            if (flushIf || haltPending) begin
                validId <= 1'b0;
            end else if (!stallId) begin
                validId <= 1'b1;
            end
            exValid <= !killId;
            idExCtrl <= killId ? '0 : ctrlId;
            exMemValid <= exValid;
            exMemCtrl <= idExCtrl;
            memWbValid <= exMemValid;
            memWbCtrl <= exMemCtrl;
        end
    end

    always_ff @(posedge Clk) begin
        if (!stallId) begin
            instrId <= instData;
            ifIdPc <= pcPlusOne;
        end
        exRs <= instrId.rType.rs;
        exRt <= instrId.rType.rt;
        exRd <= destId;
        aluOp <= aluOpId;
        idExData1 <= readData1;
        idExData2 <= readData2;
        idExImm <= {{(isaPkg::WORD_SIZE-8){instrId.iType.imm8[7]}}, instrId.iType.imm8};
        idExPc <= ifIdPc;
        exMemResult <= exResult;
        exMemStore <= fwdB;
        memRd <= exRd;
        memWbData <= exMemCtrl[ctrlPkg::C_MEM_TO_REG] ? dataRData : exMemResult;
        regWriteIdx <= memRd;
    end

    // strobe and port load as the wwd enters writeback
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            numInst <= '0;
            halted <= 1'b0;
            outputPort <= '0;
            outputStrobe <= 1'b0;
        end else begin
            outputStrobe <= exMemCtrl[ctrlPkg::C_WWD];
            if (exMemCtrl[ctrlPkg::C_WWD]) begin
                outputPort <= exMemResult;
            end
            if (memWbValid) begin
                numInst <= numInst + 1'b1;
            end
            if (memWbCtrl[ctrlPkg::C_HLT]) begin
                halted <= 1'b1;
            end
        end
    end

    memPortExclusive: assert property (@(posedge Clk) disable iff (!rstN)
        !(dataRead && dataWrite))
        else $error("data memory read and write in the same cycle");

    quietAfterHalt: assert property (@(posedge Clk) disable iff (!rstN)
        halted |-> (!outputStrobe && !dataWrite))
        else $error("activity after halt");

endmodule

`default_nettype wire

//--- source/cpuTop.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTop (
    input  logic Clk,
    input  logic rstN,
    output logic [isaPkg::WORD_SIZE-1:0] instAddr,
    input  logic [isaPkg::WORD_SIZE-1:0] instData,
    output logic [isaPkg::WORD_SIZE-1:0] dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output logic [isaPkg::WORD_SIZE-1:0] dataWData,
    input  logic [isaPkg::WORD_SIZE-1:0] dataRData,
    output logic halted,
    output logic [isaPkg::WORD_SIZE-1:0] outputPort,
    output logic outputStrobe,
    output logic [isaPkg::WORD_SIZE-1:0] numInst
);

    isaPkg::instr_u instrId;
    logic validId, stallId, flushIf, flushId, jumpId, redirectEx;
    logic [ctrlPkg::CTRL_WIDTH-1:0] ctrlId;
    logic [ctrlPkg::ALU_OP_BITS-1:0] aluOpId, aluOp;
    logic [ctrlPkg::FWD_BITS-1:0] forwardA, forwardB;
    logic [isaPkg::REG_BITS-1:0] destId, exRs, exRt, exRd, memRd, wbRd, regWriteIdx;
    logic exMemRead, exValid, memRegWrite, wbRegWrite, regWriteEn, aluEqual;
    logic [isaPkg::WORD_SIZE-1:0] readData1, readData2, regWriteData;
    logic [isaPkg::WORD_SIZE-1:0] aluA, aluB, aluResult;

    pipelineControl control0 (.*);

    pipeDatapath datapath0 (.*);

    regFile regFile0 (
        .Clk,
        .rstN,
        .rs(instrId.rType.rs),
        .rt(instrId.rType.rt),
        .readData1,
        .readData2,
        .writeIdx(regWriteIdx),
        .writeData(regWriteData),
        .writeEn(regWriteEn)
    );

    alu alu0 (
        .a(aluA),
        .b(aluB),
        .aluOp,
        .result(aluResult),
        .equal(aluEqual)
    );

endmodule

`default_nettype wire

//--- tests/cpuTb.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS = 6;
    localparam int MAX_WORDS = 12;
    localparam int MAX_OUTS = 4;
    localparam int MEM_DEPTH = 64;
    localparam int ADDR_BITS = 6;
    localparam int RUN_LIMIT = 150;
    localparam int QUIET_CYCLES = 8;

    logic Clk;
    logic rstN;
    logic [isaPkg::WORD_SIZE-1:0] instAddr;
    logic [isaPkg::WORD_SIZE-1:0] instData;
    logic [isaPkg::WORD_SIZE-1:0] dataAddr;
    logic dataRead;
    logic dataWrite;
    logic [isaPkg::WORD_SIZE-1:0] dataWData;
    logic [isaPkg::WORD_SIZE-1:0] dataRData;
    logic halted;
    logic [isaPkg::WORD_SIZE-1:0] outputPort;
    logic outputStrobe;
    logic [isaPkg::WORD_SIZE-1:0] numInst;

    logic [isaPkg::WORD_SIZE-1:0] instMem [MEM_DEPTH];
    logic [isaPkg::WORD_SIZE-1:0] dataMem [MEM_DEPTH];
    logic [isaPkg::WORD_SIZE-1:0] seedData [MEM_DEPTH];

    // program table, one row per test
    string testName [NUM_TESTS];
    isaPkg::instr_u progWords [NUM_TESTS][MAX_WORDS];
    int progLen [NUM_TESTS];
    logic [isaPkg::WORD_SIZE-1:0] expOut [NUM_TESTS][MAX_OUTS];
    int expOutCount [NUM_TESTS];
    logic [isaPkg::WORD_SIZE-1:0] expNumInst [NUM_TESTS];
    int curRow = -1;

    cpuTop dut0 (
        .Clk,
        .rstN,
        .instAddr,
        .instData,
        .dataAddr,
        .dataRead,
        .dataWrite,
        .dataWData,
        .dataRData,
        .halted,
        .outputPort,
        .outputStrobe,
        .numInst
    );

    always #(CLK_PERIOD / 2) Clk = ~Clk;

    // both memories answer in the same cycle, data only while a read is asked for
    assign instData = instMem[instAddr[ADDR_BITS-1:0]];
    assign dataRData = (dataRead === 1'b1) ? dataMem[dataAddr[ADDR_BITS-1:0]] : '0;

    always @(posedge Clk) begin
        if (dataWrite === 1'b1) begin
            dataMem[dataAddr[ADDR_BITS-1:0]] <= dataWData;
        end
    end

    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        logic feedback;
        // taps 16, 14, 13, 11
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    function automatic isaPkg::instr_u regOp(
        input logic [5:0] func,
        input logic [isaPkg::REG_BITS-1:0] rs,
        input logic [isaPkg::REG_BITS-1:0] rt,
        input logic [isaPkg::REG_BITS-1:0] rd
    );
        isaPkg::instr_u w;
        w.rType.opcode = isaPkg::OP_RTYPE;
        w.rType.rs = rs;
        w.rType.rt = rt;
        w.rType.rd = rd;
        w.rType.func = func;
        return w;
    endfunction

    function automatic isaPkg::instr_u immOp(
        input logic [3:0] opcode,
        input logic [isaPkg::REG_BITS-1:0] rs,
        input logic [isaPkg::REG_BITS-1:0] rt,
        input logic [7:0] imm8
    );
        isaPkg::instr_u w;
        w.iType.opcode = opcode;
        w.iType.rs = rs;
        w.iType.rt = rt;
        w.iType.imm8 = imm8;
        return w;
    endfunction

    function automatic isaPkg::instr_u jumpOp(input logic [11:0] target12);
        isaPkg::instr_u w;
        w.jType.opcode = isaPkg::OP_JMP;
        w.jType.target12 = target12;
        return w;
    endfunction

    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(input string name, input logic [isaPkg::WORD_SIZE-1:0] expected,
        input logic [isaPkg::WORD_SIZE-1:0] actual);
        if (actual !== expected) begin
            stopOnError($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkCount(input string name, input logic [isaPkg::WORD_SIZE-1:0] expected,
        input logic [isaPkg::WORD_SIZE-1:0] actual);
        if (actual !== expected) begin
            stopOnError($sformatf("[FAIL] %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic checkInstr(input string name, input isaPkg::instr_u expected,
        input isaPkg::instr_u actual);
        if (actual !== expected) begin
            stopOnError($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // hand-assembled words pin down the field layout of the union
    task automatic verifyEncodings();
        checkInstr("encode hlt", 16'hF01D, regOp(isaPkg::FUNC_HLT, 0, 0, 0));
        checkInstr("encode add", 16'hF6C0, regOp(isaPkg::FUNC_ADD, 1, 2, 3));
        checkInstr("encode adi", 16'h4680, immOp(isaPkg::OP_ADI, 1, 2, 8'h80));
        checkInstr("encode jmp", 16'h9004, jumpOp(12'd4));
    endtask

    task automatic newRow(input string name, input logic [isaPkg::WORD_SIZE-1:0] retired);
        curRow++;
        testName[curRow] = name;
        expNumInst[curRow] = retired;
        progLen[curRow] = 0;
        expOutCount[curRow] = 0;
    endtask

    task automatic addWord(input isaPkg::instr_u w);
        progWords[curRow][progLen[curRow]] = w;
        progLen[curRow]++;
    endtask

    task automatic expectOut(input logic [isaPkg::WORD_SIZE-1:0] value);
        expOut[curRow][expOutCount[curRow]] = value;
        expOutCount[curRow]++;
    endtask

    // one continuous bit stream, sixteen bits per word
    task automatic fillSeed();
        logic [15:0] state;
        logic [15:0] word;
        state = 16'd9;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            word = '0;
            for (int b = 0; b < 16; b++) begin
                word = {word[14:0], state[15]};
                state = lfsrNext(state);
            end
            seedData[a] = word;
        end
    endtask

    task automatic buildTable();
        newRow("aluForward", 12);
        addWord(immOp(isaPkg::OP_ADI, 0, 1, 8'h35));
        addWord(immOp(isaPkg::OP_ADI, 0, 2, 8'h0F));
        addWord(regOp(isaPkg::FUNC_ADD, 1, 2, 3));
        addWord(regOp(isaPkg::FUNC_SUB, 2, 3, 1));
        addWord(regOp(isaPkg::FUNC_AND, 1, 3, 2));
        addWord(immOp(isaPkg::OP_ADI, 0, 0, 8'h05));
        addWord(regOp(isaPkg::FUNC_ORR, 2, 0, 0));
        addWord(regOp(isaPkg::FUNC_WWD, 0, 0, 0));
        addWord(regOp(isaPkg::FUNC_WWD, 3, 0, 0));
        addWord(regOp(isaPkg::FUNC_WWD, 1, 0, 0));
        addWord(regOp(isaPkg::FUNC_WWD, 2, 0, 0));
        addWord(regOp(isaPkg::FUNC_HLT, 0, 0, 0));
        expectOut(16'h0045);
        expectOut(16'h0044);
        expectOut(16'hFFCB);
        expectOut(16'h0040);

        newRow("immediates", 10);
        addWord(immOp(isaPkg::OP_ADI, 0, 1, 8'hFB));
        addWord(immOp(isaPkg::OP_ADI, 1, 2, 8'h80));
        addWord(immOp(isaPkg::OP_LHI, 0, 3, 8'hA5));
        addWord(immOp(isaPkg::OP_ADI, 3, 3, 8'h7F));
        addWord(regOp(isaPkg::FUNC_WWD, 1, 0, 0));
        addWord(regOp(isaPkg::FUNC_WWD, 2, 0, 0));
        addWord(regOp(isaPkg::FUNC_WWD, 3, 0, 0));
        addWord(immOp(isaPkg::OP_LHI, 0, 0, 8'h12));
        addWord(regOp(isaPkg::FUNC_WWD, 0, 0, 0));
        addWord(regOp(isaPkg::FUNC_HLT, 0, 0, 0));
        expectOut(16'hFFFB);
        expectOut(16'hFF7B);
        expectOut(16'hA57F);
        expectOut(16'h1200);

        // store then reload, two load-use stalls, one seeded load
        newRow("loadStore", 12);
        addWord(immOp(isaPkg::OP_LHI, 0, 1, 8'h3C));
        addWord(immOp(isaPkg::OP_ADI, 1, 1, 8'h5A));
        addWord(immOp(isaPkg::OP_SWD, 0, 1, 8'h20));
        addWord(immOp(isaPkg::OP_LWD, 0, 2, 8'h20));
        addWord(regOp(isaPkg::FUNC_ADD, 2, 1, 3));
        addWord(regOp(isaPkg::FUNC_WWD, 3, 0, 0));
        addWord(immOp(isaPkg::OP_LWD, 0, 0, 8'h05));
        addWord(regOp(isaPkg::FUNC_WWD, 0, 0, 0));
        addWord(regOp(isaPkg::FUNC_ADD, 0, 1, 3));
        addWord(regOp(isaPkg::FUNC_WWD, 3, 0, 0));
        addWord(regOp(isaPkg::FUNC_WWD, 2, 0, 0));
        addWord(regOp(isaPkg::FUNC_HLT, 0, 0, 0));
        expectOut(16'h78B4);
        expectOut(seedData[5]);
        expectOut(seedData[5] + 16'h3C5A);
        expectOut(16'h3C5A);

        // words 3, 4 and 8 sit in squashed slots
        newRow("branches", 9);
        addWord(immOp(isaPkg::OP_ADI, 0, 1, 8'h07));
        addWord(immOp(isaPkg::OP_ADI, 0, 3, 8'h33));
        addWord(immOp(isaPkg::OP_BEQ, 1, 1, 8'h02));
        addWord(regOp(isaPkg::FUNC_WWD, 1, 0, 0));
        addWord(regOp(isaPkg::FUNC_WWD, 3, 0, 0));
        addWord(immOp(isaPkg::OP_BNE, 1, 1, 8'h01));
        addWord(regOp(isaPkg::FUNC_WWD, 1, 0, 0));
        addWord(immOp(isaPkg::OP_BNE, 3, 1, 8'h01));
        addWord(regOp(isaPkg::FUNC_WWD, 3, 0, 0));
        addWord(immOp(isaPkg::OP_BEQ, 3, 1, 8'h01));
        addWord(regOp(isaPkg::FUNC_WWD, 3, 0, 0));
        addWord(regOp(isaPkg::FUNC_HLT, 0, 0, 0));
        expectOut(16'h0007);
        expectOut(16'h0033);

        newRow("jumps", 7);
        addWord(immOp(isaPkg::OP_ADI, 0, 1, 8'h06));
        addWord(jumpOp(12'd4));
        addWord(regOp(isaPkg::FUNC_WWD, 1, 0, 0));
        addWord(regOp(isaPkg::FUNC_WWD, 1, 0, 0));
        addWord(immOp(isaPkg::OP_ADI, 0, 2, 8'h08));
        addWord(regOp(isaPkg::FUNC_JPR, 2, 0, 0));
        addWord(regOp(isaPkg::FUNC_WWD, 2, 0, 0));
        addWord(regOp(isaPkg::FUNC_WWD, 1, 0, 0));
        addWord(regOp(isaPkg::FUNC_WWD, 2, 0, 0));
        addWord(regOp(isaPkg::FUNC_WWD, 1, 0, 0));
        addWord(regOp(isaPkg::FUNC_HLT, 0, 0, 0));
        expectOut(16'h0008);
        expectOut(16'h0006);

        // nothing after the hlt may store or print
        newRow("haltStops", 3);
        addWord(immOp(isaPkg::OP_ADI, 0, 1, 8'h21));
        addWord(regOp(isaPkg::FUNC_WWD, 1, 0, 0));
        addWord(regOp(isaPkg::FUNC_HLT, 0, 0, 0));
        addWord(immOp(isaPkg::OP_SWD, 0, 1, 8'h01));
        addWord(regOp(isaPkg::FUNC_WWD, 1, 0, 0));
        addWord(immOp(isaPkg::OP_ADI, 1, 1, 8'h01));
        expectOut(16'h0021);
    endtask

    task automatic loadProgram(input int r);
        // anything past the program halts
        for (int a = 0; a < MEM_DEPTH; a++) begin
            instMem[a] = regOp(isaPkg::FUNC_HLT, 0, 0, 0);
            dataMem[a] = seedData[a];
        end
        for (int i = 0; i < progLen[r]; i++) begin
            instMem[i] = progWords[r][i];
        end
    endtask

    task automatic runRow(input int r);
        logic [isaPkg::WORD_SIZE-1:0] seen [$];
        int cycles;
        @(posedge Clk);
        #2;
        rstN = 1'b0;
        loadProgram(r);
        repeat (4) @(posedge Clk);
        #2;
        rstN = 1'b1;
        cycles = 0;
        while (halted !== 1'b1) begin
            @(negedge Clk);
            if (outputStrobe === 1'b1) begin
                seen.push_back(outputPort);
            end
            cycles++;
            if (cycles > RUN_LIMIT) begin
                stopOnError($sformatf("%s: the core never raised halted", testName[r]));
            end
        end
        repeat (QUIET_CYCLES) begin
            @(negedge Clk);
            if (outputStrobe !== 1'b0 || dataWrite !== 1'b0 || dataRead !== 1'b0
                || halted !== 1'b1) begin
                stopOnError($sformatf("%s: output or memory activity after halt",
                    testName[r]));
            end
        end
        if (seen.size() != expOutCount[r]) begin
            stopOnError($sformatf("%s: saw %0d output strobes but expected %0d",
                testName[r], seen.size(), expOutCount[r]));
        end
        for (int i = 0; i < expOutCount[r]; i++) begin
            checkWord($sformatf("%s out%0d", testName[r], i), expOut[r][i], seen[i]);
        end
        checkCount($sformatf("%s numInst", testName[r]), expNumInst[r], numInst);
    endtask

    initial begin
        Clk = 1'b0;
        rstN = 1'b0;
        fillSeed();
        buildTable();
        verifyEncodings();
        for (int r = 0; r < NUM_TESTS; r++) begin
            runRow(r);
        end
        $display("Test OK");
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        stopOnError("timeout: the programs did not finish in the allowed time");
    end

endmodule

`default_nettype wire

//--- sim.f
source/isaPkg.sv
source/ctrlPkg.sv
source/regFile.sv
source/alu.sv
source/pipelineControl.sv
source/pipeDatapath.sv
source/cpuTop.sv
tests/cpuTb.sv
